/* rtl/exu_settings.svh */
`ifndef EXU_SETTINGS_SVH
`define EXU_SETTINGS_SVH

// data and address width
`define EXU_XLEN 64

// general register file
`define EXU_REG_COUNT 32
`define EXU_REG_BITS 5

`endif

/* rtl/exu_pkg.sv */
`default_nettype none

`include "exu_settings.svh"

package exu_pkg;

    // control decodes by ranges, keep each group contiguous
    typedef enum logic [5:0] {
        OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
        OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
        OP_SB, OP_SH, OP_SW, OP_SD
    } exu_op_e;

    typedef enum logic [3:0] {
        ADD, SUB, SLT, SLTU, AND, OR, XOR, SLL, SRL, SRA, SLLW, SRLW, SRAW
    } alu_mode_e;

    // imm already selected by decode, shamt for shift-immediates
    typedef struct packed {
        exu_op_e                  op;
        logic [`EXU_REG_BITS-1:0] rd;
        logic [`EXU_REG_BITS-1:0] rs1;
        logic [`EXU_REG_BITS-1:0] rs2;
        logic [`EXU_XLEN-1:0]     imm;
        logic [`EXU_XLEN-1:0]     pc;
    } issue_t;

    typedef struct packed {
        logic                     wen;
        logic [`EXU_REG_BITS-1:0] rd;
        logic [`EXU_XLEN-1:0]     wdata;
        logic [`EXU_XLEN-1:0]     dnpc;
    } commit_t;

    typedef struct packed {
        logic                 we;
        logic [`EXU_XLEN-1:0] adr;
        logic [`EXU_XLEN-1:0] dat_w;
        logic [7:0]           sel;
    } mem_req_t;

    typedef struct packed {
        logic [`EXU_XLEN-1:0] dat_r;
        logic                 ack;
    } wb_rsp_t;

endpackage

`default_nettype wire

/* rtl/exu_control.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_control
    import exu_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     issue_valid,
    input  issue_t                   issue,
    output logic                     issue_ready,
    output logic [`EXU_REG_BITS-1:0] rs1_idx,
    output logic [`EXU_REG_BITS-1:0] rs2_idx,
    input  logic [`EXU_XLEN-1:0]     src1,
    input  logic [`EXU_XLEN-1:0]     src2,
    output exu_op_e                  op,
    output logic [`EXU_XLEN-1:0]     pc,
    output logic [`EXU_XLEN-1:0]     imm,
    output alu_mode_e                alu_mode,
    output logic [`EXU_XLEN-1:0]     alu_a,
    output logic [`EXU_XLEN-1:0]     alu_b,
    input  logic [`EXU_XLEN-1:0]     alu_y,
    input  logic [`EXU_XLEN-1:0]     dnpc,
    input  logic [`EXU_XLEN-1:0]     load_value,
    output logic                     reg_wen,
    output logic [`EXU_REG_BITS-1:0] reg_rd,
    output logic [`EXU_XLEN-1:0]     reg_wdata,
    output logic                     wb_cyc,
    output logic                     wb_stb,
    output logic [`EXU_XLEN-1:0]     mem_adr,
    output logic                     mem_store,
    input  logic                     wb_ack,
    output logic                     commit_valid,
    output commit_t                  commit
);

    typedef enum logic [1:0] {IDLE, EXEC, BUS, DONE} state_e;

    state_e state;
    issue_t inst;
    logic   accept;
    logic   finish;
    logic   is_load;
    logic   is_store;
    logic   writes_rd;

    assign issue_ready = (state == IDLE) || (state == DONE);
    assign accept      = issue_valid && issue_ready;
    // EXEC takes one cycle, BUS waits for the slave
    assign finish      = (state == EXEC) || ((state == BUS) && wb_ack);

    assign is_load   = inst.op inside {[OP_LB:OP_LWU]};
    assign is_store  = inst.op inside {[OP_SB:OP_SD]};
    assign writes_rd = !is_store && !(inst.op inside {[OP_BEQ:OP_BGEU]});

    always_ff @(posedge clk) begin
        if (reset) begin
            state        <= IDLE;
            commit_valid <= 1'b0;
        end else begin
            commit_valid <= finish;
            case (state)
                EXEC: state <= DONE;
                BUS: begin
                    if (wb_ack) begin
                        state <= DONE;
                    end
                end
                default: begin
                    if (accept) begin
                        state <= (issue.op inside {[OP_LB:OP_SD]}) ? BUS : EXEC;
                    end else begin
                        state <= IDLE;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            inst <= issue;
        end
        if (finish) begin
            commit <= '{wen: reg_wen, rd: inst.rd, wdata: reg_wdata, dnpc: dnpc};
        end
    end

    assign op      = inst.op;
    assign pc      = inst.pc;
    assign imm     = inst.imm;
    assign rs1_idx = inst.rs1;
    assign rs2_idx = inst.rs2;

    // operand steering
    assign alu_a = (inst.op inside {OP_AUIPC, OP_JAL}) ? inst.pc : src1;
    assign alu_b = (inst.op inside {[OP_ADD:OP_AND], [OP_ADDW:OP_SRAW]}) ? src2 : inst.imm;

    always_comb begin
        case (inst.op)
            OP_SUB, OP_SUBW:   alu_mode = SUB;
            OP_SLT, OP_SLTI:   alu_mode = SLT;
            OP_SLTU, OP_SLTIU: alu_mode = SLTU;
            OP_AND, OP_ANDI:   alu_mode = AND;
            OP_OR, OP_ORI:     alu_mode = OR;
            OP_XOR, OP_XORI:   alu_mode = XOR;
            OP_SLL, OP_SLLI:   alu_mode = SLL;
            OP_SRL, OP_SRLI:   alu_mode = SRL;
            OP_SRA, OP_SRAI:   alu_mode = SRA;
            OP_SLLW, OP_SLLIW: alu_mode = SLLW;
            OP_SRLW, OP_SRLIW: alu_mode = SRLW;
            OP_SRAW, OP_SRAIW: alu_mode = SRAW;
            default:           alu_mode = ADD;
        endcase
    end

    always_comb begin
        if (is_load) begin
            reg_wdata = load_value;
        end else if (inst.op inside {[OP_ADDW:OP_SRAIW]}) begin
            reg_wdata = `EXU_XLEN'($signed(alu_y[31:0]));
        end else if (inst.op == OP_LUI) begin
            reg_wdata = inst.imm;
        end else if (inst.op inside {OP_JAL, OP_JALR}) begin
            reg_wdata = inst.pc + `EXU_XLEN'(4);
        end else begin
            reg_wdata = alu_y;
        end
    end

    assign reg_wen = finish && writes_rd && (inst.rd != '0);
    assign reg_rd  = inst.rd;

    assign wb_cyc    = (state == BUS);
    assign wb_stb    = (state == BUS);
    assign mem_adr   = alu_y;
    assign mem_store = is_store;

    // request held until the slave acks
    a_wb_hold: assert property (@(posedge clk) disable iff (reset)
        (wb_stb && !wb_ack) |=> (wb_cyc && wb_stb && $stable(mem_adr) && $stable(mem_store)));

    // bus cycles only for loads and stores
    a_bus_only_mem: assert property (@(posedge clk) disable iff (reset)
        wb_cyc |-> (is_load || is_store));

    // lane logic only handles accesses inside one doubleword
    a_no_cross: assert property (@(posedge clk) disable iff (reset)
        wb_cyc |-> ((inst.op inside {OP_LB, OP_LBU, OP_SB})
                || ((inst.op inside {OP_LH, OP_LHU, OP_SH}) && (mem_adr[2:0] != 3'd7))
                || ((inst.op inside {OP_LW, OP_LWU, OP_SW}) && (mem_adr[2:0] <= 3'd4))
                || (mem_adr[2:0] == 3'd0)));

endmodule

`default_nettype wire

/* rtl/exu_regfile.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_regfile (
    input  logic                     clk,
    input  logic                     reset,
    input  logic [`EXU_REG_BITS-1:0] rs1_idx,
    input  logic [`EXU_REG_BITS-1:0] rs2_idx,
    output logic [`EXU_XLEN-1:0]     src1,
    output logic [`EXU_XLEN-1:0]     src2,
    input  logic                     wen,
    input  logic [`EXU_REG_BITS-1:0] rd,
    input  logic [`EXU_XLEN-1:0]     wdata
);

    logic [`EXU_XLEN-1:0] regs [`EXU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `EXU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (rd != '0)) begin
            regs[rd] <= wdata;
        end
    end

    // x0 hardwired to zero
    assign src1 = (rs1_idx == '0) ? '0 : regs[rs1_idx];
    assign src2 = (rs2_idx == '0) ? '0 : regs[rs2_idx];

    // control drops x0 writes before they get here
    a_no_x0_write: assert property (@(posedge clk) disable iff (reset)
        wen |-> (rd != '0));

endmodule

`default_nettype wire

/* rtl/exu_alu.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_alu
    import exu_pkg::*;
(
    input  alu_mode_e            mode,
    input  logic [`EXU_XLEN-1:0] a,
    input  logic [`EXU_XLEN-1:0] b,
    output logic [`EXU_XLEN-1:0] y
);

    logic [$clog2(`EXU_XLEN)-1:0] shamt;
    logic [4:0]                   shamt_w;

    assign shamt   = b[$clog2(`EXU_XLEN)-1:0];
    assign shamt_w = b[4:0];

    always_comb begin
        case (mode)
            ADD:  y = a + b;
            SUB:  y = a - b;
            SLT:  y = `EXU_XLEN'($signed(a) < $signed(b));
            SLTU: y = `EXU_XLEN'(a < b);
            AND:  y = a & b;
            OR:   y = a | b;
            XOR:  y = a ^ b;
            SLL:  y = a << shamt;
            SRL:  y = a >> shamt;
            SRA:  y = $signed(a) >>> shamt;
            // word shifts, upper half left zero for control to extend
            SLLW: y = {32'b0, a[31:0] << shamt_w};
            SRLW: y = {32'b0, a[31:0] >> shamt_w};
            SRAW: y = {32'b0, $signed(a[31:0]) >>> shamt_w};
            default: y = a + b;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/exu_lsu_align.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_lsu_align
    import exu_pkg::*;
(
    input  exu_op_e              op,
    input  logic [`EXU_XLEN-1:0] adr,
    input  logic [`EXU_XLEN-1:0] store_src,
    input  logic [`EXU_XLEN-1:0] dat_r,
    output logic [`EXU_XLEN-1:0] dat_w,
    output logic [7:0]           sel,
    output logic [`EXU_XLEN-1:0] load_value
);

    logic [2:0]                   lane;
    logic [$clog2(`EXU_XLEN)-1:0] shift;
    logic [7:0]                   size_mask;
    logic [`EXU_XLEN-1:0]         store_data;
    logic [`EXU_XLEN-1:0]         lane_data;

    assign lane  = adr[2:0];
    // byte lane to bit offset
    assign shift = {lane, 3'b000};

    always_comb begin
        case (op)
            OP_SB, OP_LB, OP_LBU: begin
                size_mask  = 8'h01;
                store_data = `EXU_XLEN'(store_src[7:0]);
            end
            OP_SH, OP_LH, OP_LHU: begin
                size_mask  = 8'h03;
                store_data = `EXU_XLEN'(store_src[15:0]);
            end
            OP_SW, OP_LW, OP_LWU: begin
                size_mask  = 8'h0f;
                store_data = `EXU_XLEN'(store_src[31:0]);
            end
            default: begin
                size_mask  = 8'hff;
                store_data = store_src;
            end
        endcase
    end

    assign dat_w = store_data << shift;
    assign sel   = size_mask << lane;

    // load data moved down to bit 0 first
    assign lane_data = dat_r >> shift;

    always_comb begin
        case (op)
            OP_LB:   load_value = `EXU_XLEN'($signed(lane_data[7:0]));
            OP_LBU:  load_value = `EXU_XLEN'(lane_data[7:0]);
            OP_LH:   load_value = `EXU_XLEN'($signed(lane_data[15:0]));
            OP_LHU:  load_value = `EXU_XLEN'(lane_data[15:0]);
            OP_LW:   load_value = `EXU_XLEN'($signed(lane_data[31:0]));
            OP_LWU:  load_value = `EXU_XLEN'(lane_data[31:0]);
            default: load_value = dat_r;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/exu_next_pc.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_next_pc
    import exu_pkg::*;
(
    input  exu_op_e              op,
    input  logic [`EXU_XLEN-1:0] pc,
    input  logic [`EXU_XLEN-1:0] imm,
    input  logic [`EXU_XLEN-1:0] src1,
    input  logic [`EXU_XLEN-1:0] src2,
    input  logic [`EXU_XLEN-1:0] alu_y,
    output logic [`EXU_XLEN-1:0] dnpc
);

    logic eq;
    logic lt;
    logic ltu;
    logic taken;

    assign eq  = (src1 == src2);
    assign lt  = ($signed(src1) < $signed(src2));
    assign ltu = (src1 < src2);

    always_comb begin
        case (op)
            OP_BEQ:  taken = eq;
            OP_BNE:  taken = !eq;
            OP_BLT:  taken = lt;
            OP_BGE:  taken = !lt;
            OP_BLTU: taken = ltu;
            OP_BGEU: taken = !ltu;
            default: taken = 1'b0;
        endcase
    end

    // jumps take the ALU sum, JALR drops bit 0
    always_comb begin
        if (op == OP_JAL) begin
            dnpc = alu_y;
        end else if (op == OP_JALR) begin
            dnpc = {alu_y[`EXU_XLEN-1:1], 1'b0};
        end else if (taken) begin
            dnpc = pc + imm;
        end else begin
            dnpc = pc + `EXU_XLEN'(4);
        end
    end

endmodule

`default_nettype wire

/* rtl/exu_top.sv */
`timescale 1ns/1ns
`default_nettype none

`include "exu_settings.svh"

module exu_top
    import exu_pkg::*;
(
    input  logic     clk,
    input  logic     reset,
    input  logic     issue_valid,
    input  issue_t   issue,
    output logic     issue_ready,
    output logic     commit_valid,
    output commit_t  commit,
    output logic     wb_cyc,
    output logic     wb_stb,
    output mem_req_t wb_req,
    input  wb_rsp_t  wb_rsp
);

    logic [`EXU_REG_BITS-1:0] rs1_idx;
    logic [`EXU_REG_BITS-1:0] rs2_idx;
    logic [`EXU_XLEN-1:0]     src1;
    logic [`EXU_XLEN-1:0]     src2;
    exu_op_e                  op;
    logic [`EXU_XLEN-1:0]     pc;
    logic [`EXU_XLEN-1:0]     imm;
    alu_mode_e                alu_mode;
    logic [`EXU_XLEN-1:0]     alu_a;
    logic [`EXU_XLEN-1:0]     alu_b;
    logic [`EXU_XLEN-1:0]     alu_y;
    logic [`EXU_XLEN-1:0]     dnpc;
    logic [`EXU_XLEN-1:0]     load_value;
    logic                     reg_wen;
    logic [`EXU_REG_BITS-1:0] reg_rd;
    logic [`EXU_XLEN-1:0]     reg_wdata;
    logic [`EXU_XLEN-1:0]     mem_adr;
    logic                     mem_store;
    logic [`EXU_XLEN-1:0]     dat_w;
    logic [7:0]               sel;

    exu_control u_control (
        .clk, .reset, .issue_valid, .issue, .issue_ready,
        .rs1_idx, .rs2_idx, .src1, .src2, .op, .pc, .imm,
        .alu_mode, .alu_a, .alu_b, .alu_y, .dnpc, .load_value,
        .reg_wen, .reg_rd, .reg_wdata,
        .wb_cyc, .wb_stb, .mem_adr, .mem_store,
        .wb_ack(wb_rsp.ack),
        .commit_valid, .commit
    );

    exu_regfile u_regfile (
        .clk, .reset, .rs1_idx, .rs2_idx, .src1, .src2,
        .wen(reg_wen),
        .rd(reg_rd),
        .wdata(reg_wdata)
    );

    exu_alu u_alu (
        .mode(alu_mode),
        .a(alu_a),
        .b(alu_b),
        .y(alu_y)
    );

    exu_next_pc u_next_pc (
        .op, .pc, .imm, .src1, .src2, .alu_y, .dnpc
    );

    exu_lsu_align u_lsu_align (
        .op,
        .adr(mem_adr),
        .store_src(src2),
        .dat_r(wb_rsp.dat_r),
        .dat_w,
        .sel,
        .load_value
    );

    assign wb_req = '{we: mem_store, adr: mem_adr, dat_w: dat_w, sel: sel};

endmodule

`default_nettype wire

/* test/exu_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module exu_tb
    import exu_pkg::*;
;

    // about 70 instructions at up to 8 cycles each, with ample margin
    localparam int WATCHDOG_CYCLES = 2000;

    logic     clk;
    logic     reset;
    logic     issue_valid;
    issue_t   issue;
    logic     issue_ready;
    logic     commit_valid;
    commit_t  commit;
    logic     wb_cyc;
    logic     wb_stb;
    mem_req_t wb_req;
    wb_rsp_t  wb_rsp;

    logic [63:0] shadow [32];
    logic [63:0] ref_mem [256];
    logic [63:0] mem [256];
    logic [63:0] cur_pc;
    int          seed = 29;
    int          errors = 0;
    int          checks = 0;

    exu_top u_exu_top (
        .clk, .reset, .issue_valid, .issue, .issue_ready,
        .commit_valid, .commit, .wb_cyc, .wb_stb, .wb_req, .wb_rsp
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    function automatic logic [63:0] fill_word(input logic [7:0] idx);
        return {8{idx}} ^ 64'h0f1e_2d3c_4b5a_6978;
    endfunction

    function automatic logic [63:0] byte_mask(input logic [7:0] s);
        return {{8{s[7]}}, {8{s[6]}}, {8{s[5]}}, {8{s[4]}},
                {8{s[3]}}, {8{s[2]}}, {8{s[1]}}, {8{s[0]}}};
    endfunction

    function automatic logic [63:0] sext32(input logic [31:0] v);
        return {{32{v[31]}}, v};
    endfunction

    // bytes touched by an access, as a lane mask at offset 0
    function automatic logic [7:0] size_sel(input exu_op_e op);
        case (op)
            OP_LB, OP_LBU, OP_SB: return 8'h01;
            OP_LH, OP_LHU, OP_SH: return 8'h03;
            OP_LW, OP_LWU, OP_SW: return 8'h0f;
            default:              return 8'hff;
        endcase
    endfunction

    // Wishbone slave, ack after 0 to 3 wait cycles
    initial begin
        int delay;
        logic [63:0] m;
        wb_rsp = '0;
        delay = -1;
        for (int i = 0; i < 256; i++) begin
            mem[i] = fill_word(8'(i));
        end
        forever begin
            @(posedge clk);
            #1;
            wb_rsp.ack = 1'b0;
            if (wb_cyc && wb_stb) begin
                if (delay < 0) begin
                    delay = {$random(seed)} % 4;
                end
                if (delay == 0) begin
                    m = byte_mask(wb_req.sel);
                    if (wb_req.we) begin
                        mem[wb_req.adr[10:3]] = (mem[wb_req.adr[10:3]] & ~m) | (wb_req.dat_w & m);
                    end
                    wb_rsp.dat_r = mem[wb_req.adr[10:3]];
                    wb_rsp.ack = 1'b1;
                    delay = -1;
                end else begin
                    delay--;
                end
            end
        end
    end

    task automatic compare_field(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h exp %h", $time, name, got, exp);
        end
    endtask

    task automatic check_commit(input commit_t got, input commit_t exp);
        compare_field("commit.wen", 64'(got.wen), 64'(exp.wen));
        compare_field("commit.rd", 64'(got.rd), 64'(exp.rd));
        if (exp.wen) begin
            compare_field("commit.wdata", got.wdata, exp.wdata);
        end
        compare_field("commit.dnpc", got.dnpc, exp.dnpc);
    endtask

    task automatic check_req(input mem_req_t got, input mem_req_t exp, input logic full);
        compare_field("wb_req.we", 64'(got.we), 64'(exp.we));
        compare_field("wb_req.adr", got.adr, exp.adr);
        compare_field("wb_req.sel", 64'(got.sel), 64'(exp.sel));
        if (full) begin
            compare_field("wb_req.dat_w", got.dat_w, exp.dat_w);
        end
    endtask

    task automatic check_ready(input logic got, input logic exp);
        compare_field("issue_ready", 64'(got), 64'(exp));
    endtask

    // expected commit and bus request from the ISA rules and the shadow state
    function automatic void predict(input issue_t ins, output commit_t c, output mem_req_t r);
        logic [63:0] a;
        logic [63:0] b;
        logic [63:0] v;
        logic [63:0] raw;
        logic [63:0] adr;
        logic [7:0]  size;
        logic        taken;
        a = shadow[ins.rs1];
        b = shadow[ins.rs2];
        adr = a + ins.imm;
        size = size_sel(ins.op);
        raw = ref_mem[adr[10:3]] >> {adr[2:0], 3'b000};
        v = '0;
        taken = 1'b0;
        c = '{wen: 1'b1, rd: ins.rd, wdata: '0, dnpc: ins.pc + 64'd4};
        r = '{we: 1'b0, adr: adr, dat_w: '0, sel: size << adr[2:0]};
        case (ins.op)
            OP_ADD:   v = a + b;
            OP_SUB:   v = a - b;
            OP_SLL:   v = a << b[5:0];
            OP_SLT:   v = {63'b0, $signed(a) < $signed(b)};
            OP_SLTU:  v = {63'b0, a < b};
            OP_XOR:   v = a ^ b;
            OP_SRL:   v = a >> b[5:0];
            OP_SRA:   v = $signed(a) >>> b[5:0];
            OP_OR:    v = a | b;
            OP_AND:   v = a & b;
            OP_ADDI:  v = a + ins.imm;
            OP_SLTI:  v = {63'b0, $signed(a) < $signed(ins.imm)};
            OP_SLTIU: v = {63'b0, a < ins.imm};
            OP_XORI:  v = a ^ ins.imm;
            OP_ORI:   v = a | ins.imm;
            OP_ANDI:  v = a & ins.imm;
            OP_SLLI:  v = a << ins.imm[5:0];
            OP_SRLI:  v = a >> ins.imm[5:0];
            OP_SRAI:  v = $signed(a) >>> ins.imm[5:0];
            OP_ADDW:  v = sext32(a[31:0] + b[31:0]);
            OP_SUBW:  v = sext32(a[31:0] - b[31:0]);
            OP_SLLW:  v = sext32(a[31:0] << b[4:0]);
            OP_SRLW:  v = sext32(a[31:0] >> b[4:0]);
            OP_SRAW:  v = sext32($signed(a[31:0]) >>> b[4:0]);
            OP_ADDIW: v = sext32(a[31:0] + ins.imm[31:0]);
            OP_SLLIW: v = sext32(a[31:0] << ins.imm[4:0]);
            OP_SRLIW: v = sext32(a[31:0] >> ins.imm[4:0]);
            OP_SRAIW: v = sext32($signed(a[31:0]) >>> ins.imm[4:0]);
            OP_LUI:   v = ins.imm;
            OP_AUIPC: v = ins.pc + ins.imm;
            OP_JAL: begin
                v = ins.pc + 64'd4;
                c.dnpc = ins.pc + ins.imm;
            end
            OP_JALR: begin
                v = ins.pc + 64'd4;
                c.dnpc = adr & ~64'd1;
            end
            OP_BEQ:   taken = (a == b);
            OP_BNE:   taken = (a != b);
            OP_BLT:   taken = ($signed(a) < $signed(b));
            OP_BGE:   taken = ($signed(a) >= $signed(b));
            OP_BLTU:  taken = (a < b);
            OP_BGEU:  taken = (a >= b);
            OP_LB:    v = {{56{raw[7]}}, raw[7:0]};
            OP_LBU:   v = {56'b0, raw[7:0]};
            OP_LH:    v = {{48{raw[15]}}, raw[15:0]};
            OP_LHU:   v = {48'b0, raw[15:0]};
            OP_LW:    v = sext32(raw[31:0]);
            OP_LWU:   v = {32'b0, raw[31:0]};
            OP_LD:    v = raw;
            default: begin
                // stores
                r.we = 1'b1;
                r.dat_w = (b & byte_mask(size)) << {adr[2:0], 3'b000};
            end
        endcase
        if (ins.op inside {[OP_BEQ:OP_BGEU], [OP_SB:OP_SD]}) begin
            c.wen = 1'b0;
        end
        if (taken) begin
            c.dnpc = ins.pc + ins.imm;
        end
        if (ins.rd == '0) begin
            c.wen = 1'b0;
        end
        c.wdata = v;
    endfunction

    task automatic issue_and_wait(input issue_t ins, input logic is_mem, input mem_req_t exp_req,
                                  input logic full_req, output commit_t got);
        int   cycles;
        logic done;
        logic saw_bus;
        @(posedge clk);
        #1;
        issue = ins;
        issue_valid = 1'b1;
        @(negedge clk);
        while (!issue_ready) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        issue_valid = 1'b0;
        cycles = 0;
        done = 1'b0;
        saw_bus = 1'b0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (commit_valid) begin
                done = 1'b1;
            end else begin
                check_ready(issue_ready, 1'b0);
                if (wb_cyc) begin
                    saw_bus = 1'b1;
                    compare_field("wb_stb", 64'(wb_stb), 64'd1);
                    check_req(wb_req, exp_req, full_req);
                end
            end
        end
        got = commit;
        check_ready(issue_ready, 1'b1);
        compare_field("wb_cyc", 64'(wb_cyc), 64'd0);
        if (is_mem && !saw_bus) begin
            errors++;
            $display("memory instruction at pc %h never started a bus cycle", ins.pc);
        end
        if (!is_mem && (saw_bus || cycles != 2)) begin
            errors++;
            $display("instruction at pc %h took %0d cycles or used the bus", ins.pc, cycles);
        end
    endtask

    task automatic run(input exu_op_e op, input int rd, input int rs1, input int rs2,
                       input logic [63:0] imm);
        issue_t   ins;
        commit_t  exp_c;
        commit_t  got;
        mem_req_t exp_r;
        logic     is_mem;
        logic [63:0] m;
        ins.op = op;
        ins.rd = 5'(rd);
        ins.rs1 = 5'(rs1);
        ins.rs2 = 5'(rs2);
        ins.imm = imm;
        ins.pc = cur_pc;
        predict(ins, exp_c, exp_r);
        is_mem = op inside {OP_LB, OP_LH, OP_LW, OP_LD, OP_LBU, OP_LHU, OP_LWU,
                            OP_SB, OP_SH, OP_SW, OP_SD};
        issue_and_wait(ins, is_mem, exp_r, exp_r.we, got);
        check_commit(got, exp_c);
        if (exp_c.wen) begin
            shadow[exp_c.rd] = exp_c.wdata;
        end
        if (exp_r.we) begin
            m = byte_mask(exp_r.sel);
            ref_mem[exp_r.adr[10:3]] = (ref_mem[exp_r.adr[10:3]] & ~m) | (exp_r.dat_w & m);
        end
        cur_pc = exp_c.dnpc;
    endtask

    task automatic check_after_reset();
        @(negedge clk);
        check_ready(issue_ready, 1'b1);
        compare_field("commit_valid", 64'(commit_valid), 64'd0);
        compare_field("wb_cyc", 64'(wb_cyc), 64'd0);
    endtask

    task automatic test_alu_ops();
        run(OP_ADDI, 1, 0, 0, -64'd5);
        run(OP_ADDI, 2, 0, 0, 64'h7f3);
        run(OP_ADDI, 3, 0, 0, 3);
        run(OP_ADD, 4, 1, 2, 0);
        run(OP_SUB, 5, 1, 2, 0);
        run(OP_SLT, 6, 1, 2, 0);
        run(OP_SLTU, 7, 1, 2, 0);
        run(OP_XOR, 8, 1, 2, 0);
        run(OP_OR, 9, 1, 2, 0);
        run(OP_AND, 10, 1, 2, 0);
        run(OP_SLL, 11, 2, 3, 0);
        run(OP_SRL, 12, 1, 3, 0);
        run(OP_SRA, 13, 1, 3, 0);
        run(OP_SLTI, 14, 2, 0, -64'd1);
        run(OP_SLTIU, 15, 2, 0, -64'd1);
        run(OP_XORI, 16, 2, 0, 64'h0ff);
        run(OP_ORI, 17, 2, 0, 64'h100);
        run(OP_ANDI, 18, 1, 0, 64'h0f0);
        run(OP_SLLI, 19, 2, 0, 52);
        run(OP_SRLI, 20, 1, 0, 60);
        run(OP_SRAI, 21, 19, 0, 8);
        run(OP_LUI, 22, 0, 0, 64'hffff_ffff_8000_0000);
        // word forms, results sign-extended from bit 31
        run(OP_ADDW, 23, 22, 22, 0);
        run(OP_SUBW, 24, 0, 2, 0);
        run(OP_ADDIW, 25, 22, 0, -64'd1);
        run(OP_SLLIW, 26, 2, 0, 21);
        run(OP_SLLW, 27, 2, 3, 0);
        run(OP_SRLW, 28, 22, 3, 0);
        run(OP_SRAW, 29, 22, 3, 0);
        run(OP_SRLIW, 30, 1, 0, 4);
        run(OP_SRAIW, 31, 1, 0, 4);
        run(OP_AUIPC, 4, 0, 0, 64'h1000);
    endtask

    task automatic test_x0();
        run(OP_ADDI, 0, 2, 0, 5);
        run(OP_ADD, 5, 0, 2, 0);
        run(OP_OR, 6, 0, 0, 0);
    endtask

    task automatic test_branches();
        run(OP_BEQ, 0, 3, 3, 16);
        run(OP_BNE, 0, 3, 3, 16);
        run(OP_BLT, 0, 1, 2, -64'd8);
        run(OP_BGE, 0, 1, 2, 64);
        run(OP_BLTU, 0, 1, 2, 64);
        run(OP_BGEU, 0, 1, 2, 32);
        run(OP_JAL, 7, 0, 0, 64'h100);
        // target 0x803, bit 0 dropped
        run(OP_JALR, 8, 2, 0, 16);
        run(OP_JALR, 9, 3, 0, -64'd2);
    endtask

    task automatic test_stores();
        run(OP_ADDI, 10, 0, 0, 64'h100);
        run(OP_XOR, 11, 8, 19, 0);
        run(OP_SD, 0, 10, 11, 0);
        run(OP_SW, 0, 10, 2, 8);
        run(OP_SW, 0, 10, 8, 12);
        run(OP_SH, 0, 10, 11, 16);
        run(OP_SH, 0, 10, 1, 18);
        run(OP_SH, 0, 10, 2, 22);
        run(OP_SB, 0, 10, 11, 25);
        run(OP_SB, 0, 10, 1, 31);
        run(OP_SB, 0, 10, 2, 28);
        run(OP_SW, 0, 10, 11, 36);
    endtask

    task automatic test_loads();
        run(OP_LD, 12, 10, 0, 0);
        run(OP_LW, 13, 10, 0, 8);
        run(OP_LWU, 14, 10, 0, 12);
        run(OP_LW, 15, 10, 0, 12);
        run(OP_LH, 16, 10, 0, 18);
        run(OP_LHU, 17, 10, 0, 18);
        run(OP_LH, 18, 10, 0, 22);
        run(OP_LB, 19, 10, 0, 31);
        run(OP_LBU, 20, 10, 0, 31);
        run(OP_LB, 21, 10, 0, 25);
        run(OP_LBU, 22, 10, 0, 28);
        run(OP_LWU, 23, 10, 0, 36);
        // untouched doubleword, fill pattern
        run(OP_LD, 24, 10, 0, 64);
        run(OP_LH, 25, 10, 0, 70);
    endtask

    initial begin
        reset = 1'b1;
        issue_valid = 1'b0;
        issue = '0;
        cur_pc = 64'h0000_0000_8000_0000;
        for (int i = 0; i < 32; i++) begin
            shadow[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            ref_mem[i] = fill_word(8'(i));
        end
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        check_after_reset();
        test_alu_ops();
        test_x0();
        test_branches();
        test_stores();
        test_loads();
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout, the tests did not finish within %0d clock cycles", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+rtl
rtl/exu_pkg.sv
rtl/exu_control.sv
rtl/exu_regfile.sv
rtl/exu_alu.sv
rtl/exu_lsu_align.sv
rtl/exu_next_pc.sv
rtl/exu_top.sv
test/exu_tb.sv

/* run_sim.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module exu_tb --Mdir obj_dir -o exu_sim

./obj_dir/exu_sim > sim.log 2>&1
cat sim.log

if grep -q "^Test passed$" sim.log; then
    echo "simulation PASS"
else
    echo "simulation FAIL, see sim.log"
    exit 1
fi
